// ==== Makefile ====
# Verilator flow for the L1 instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_icache
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the simulator output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
verilog/icache_pkg.sv
verilog/icache_array_if.sv
verilog/icache_ram.sv
verilog/icache_tag_array.sv
verilog/icache_data_array.sv
verilog/icache_ctrl.sv
verilog/l1_icache.sv
verif/l2_mem_model.sv
verif/tb_l1_icache.sv

// ==== verif/l2_mem_model.sv ====
`timescale 1ns/1ps

module l2_mem_model #(
    parameter logic [31:0] data_key  = 32'h0,   // XOR pattern of the L2 data rule
    parameter int          max_delay = 8        // Longest answer delay in cycles
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          l2_req,     // Line request strobe
    input  logic [icache_pkg::addr_w-1:0] l2_addr,    // Line aligned
    output logic                          l2_valid,   // Line return strobe
    output icache_pkg::line_t             l2_line
);

    // Whole line from the data rule, word 0 in the low bits
    function automatic icache_pkg::line_t make_line(input logic [31:0] base);
        icache_pkg::line_t line;
        line = '0;
        for (int w = 0; w < 16; w++) begin
            line[w*32 +: 32] = (base + 32'(w * 4)) ^ data_key;  // Byte address of word w
        end
        return line;
    endfunction

    // One request at a time, the cache never has two outstanding
    initial begin
        int unsigned delay;
        logic [31:0] base;
        l2_valid = 1'b0;
        l2_line  = '0;
        forever begin
            @(negedge clk);                          // Request is stable mid cycle
            if (rst_n && l2_req) begin
                base  = l2_addr;
                delay = 1 + ($urandom % max_delay);  // 1 to 8 cycles
                repeat (delay) @(posedge clk);
                l2_line  <= make_line(base);
                l2_valid <= 1'b1;
                @(posedge clk);
                l2_valid <= 1'b0;                    // Single cycle pulse
            end
        end
    end

endmodule

// ==== verif/tb_l1_icache.sv ====
`timescale 1ns/1ps

module tb_l1_icache;

    localparam int          clk_period   = 100;
    localparam logic [31:0] data_key     = 32'h1c0d_e000;  // L2 word = byte address ^ key
    localparam int          max_fetches  = 40;
    localparam int          fetch_cycles = 20;             // Worst case cycles per fetch
    localparam int          rsp_limit    = 40;             // Cycles to wait for rsp_valid

    logic                          clk;
    logic                          rst_n;
    logic                          fetch;
    logic [icache_pkg::addr_w-1:0] fetch_addr;
    logic                          l2_valid;
    icache_pkg::line_t             l2_line;
    logic                          busy;
    logic                          rsp_valid;
    logic [icache_pkg::word_w-1:0] rsp_word;
    logic                          l2_req;
    logic [icache_pkg::addr_w-1:0] l2_addr;

    // Reference state per set with valid bits, tags and next victim
    logic                          mdl_valid [icache_pkg::sets][icache_pkg::ways];
    icache_pkg::tag_t              mdl_tag   [icache_pkg::sets][icache_pkg::ways];
    logic [icache_pkg::way_w-1:0]  mdl_lru   [icache_pkg::sets];

    logic        exp_miss = 1'b0;       // Prediction for the fetch in flight
    logic [31:0] exp_word = '0;
    logic [31:0] exp_line_addr = '0;
    logic        seen_fetch;            // First fetch has happened
    logic        req_seen;              // l2_req already issued for this fetch
    int          errors = 0;
    int          fetches = 0;
    int          misses = 0;
    int          tests = 0;

    l1_icache dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .l2_valid   (l2_valid),
        .l2_line    (l2_line),
        .busy       (busy),
        .rsp_valid  (rsp_valid),
        .rsp_word   (rsp_word),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr)
    );

    l2_mem_model #(.data_key(data_key), .max_delay(8)) l2_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .l2_req   (l2_req),
        .l2_addr  (l2_addr),
        .l2_valid (l2_valid),
        .l2_line  (l2_line)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_fetch <= 1'b0;
            req_seen   <= 1'b0;
        end else if (fetch) begin
            seen_fetch <= 1'b1;
            req_seen   <= 1'b0;                  // A new fetch may raise a new request
        end else if (l2_req) begin
            req_seen <= 1'b1;
        end
    end

    // Outputs stay low until the core asks for something
    a_reset_quiet : assert property (
        @(posedge clk) disable iff (!rst_n) !seen_fetch |-> !busy && !rsp_valid && !l2_req
    ) else begin
        errors++;
        $display("FAILED t=%0t busy,rsp_valid,l2_req expected 000 actual %b%b%b", $time,
                 $sampled(busy), $sampled(rsp_valid), $sampled(l2_req));
    end

    a_hit_latency : assert property (
        @(posedge clk) disable iff (!rst_n) fetch && !exp_miss |-> ##2 rsp_valid
    ) else begin
        errors++;
        $display("FAILED t=%0t rsp_valid expected 1 actual %b", $time, $sampled(rsp_valid));
    end

    a_miss_request : assert property (
        @(posedge clk) disable iff (!rst_n)
            fetch && exp_miss |-> ##2 (l2_req && (l2_addr == exp_line_addr))
    ) else begin
        errors++;
        $display("FAILED t=%0t l2_addr expected %h actual %h (l2_req %b)", $time,
                 exp_line_addr, $sampled(l2_addr), $sampled(l2_req));
    end

    // One request per predicted miss and none on a hit
    a_req_expected : assert property (
        @(posedge clk) disable iff (!rst_n) l2_req |-> exp_miss && !req_seen
    ) else begin
        errors++;
        $display("FAILED t=%0t l2_req expected 0 actual %b", $time, $sampled(l2_req));
    end

    a_rsp_word : assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> (rsp_word == exp_word)
    ) else begin
        errors++;
        $display("FAILED t=%0t rsp_word expected %h actual %h", $time, exp_word,
                 $sampled(rsp_word));
    end

    function automatic logic [31:0] rule_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ data_key;   // Word aligned byte address
    endfunction

    function automatic logic [31:0] make_addr(input icache_pkg::tag_t tag,
                                              input logic [4:0] idx, input logic [3:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    // Hit check and LRU update with refill into the first invalid way else the LRU way
    task automatic update_model(input logic [31:0] addr, output logic miss);
        logic [4:0]                   idx;
        icache_pkg::tag_t             tag;
        logic [icache_pkg::way_w-1:0] way;
        idx  = addr[10:6];
        tag  = addr[31:11];
        miss = 1'b1;
        way  = mdl_lru[idx];
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (mdl_valid[idx][w] && (mdl_tag[idx][w] == tag)) begin
                miss = 1'b0;
                way  = icache_pkg::way_w'(w);
            end
        end
        if (miss) begin
            for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
                if (!mdl_valid[idx][w]) way = icache_pkg::way_w'(w);
            end
            mdl_valid[idx][way] = 1'b1;
            mdl_tag[idx][way]   = tag;
        end
        mdl_lru[idx] = ~way;                     // Point away from the way just used
    endtask

    task automatic fetch_word(input logic [31:0] addr);
        logic miss;
        int   waited;
        @(negedge clk);
        while (busy) @(negedge clk);
        update_model(addr, miss);
        @(posedge clk);
        fetch         <= 1'b1;
        fetch_addr    <= addr;
        exp_miss      <= miss;
        exp_word      <= rule_word(addr);
        exp_line_addr <= {addr[31:6], 6'b0};
        @(posedge clk);
        fetch <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rsp_valid && (waited < rsp_limit)) begin
            @(negedge clk);
            waited++;
        end
        if (!rsp_valid) begin
            errors++;
            $display("no response to the fetch of %h within %0d cycles", addr, rsp_limit);
        end
        fetches++;
        if (miss) misses++;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %0d %s done, %0d fetches, %0d failures so far",
                 tests, name, fetches, errors);
    endtask

    initial begin
        logic [4:0]       set_sel;
        icache_pkg::tag_t tag_sel;
        logic [3:0]       word_sel;
        void'($urandom(32'hea2c));
        rst_n      = 1'b0;
        fetch      = 1'b0;
        fetch_addr = '0;
        for (int s = 0; s < icache_pkg::sets; s++) begin
            mdl_lru[s] = '0;
            for (int w = 0; w < icache_pkg::ways; w++) mdl_valid[s][w] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);               // Idle window for the quiet check
        report_test("reset quiet");
        fetch_word(32'h0000_1234);               // Cold miss for tag 2 in set 8 at word 13
        report_test("cold miss");
        for (int w = 0; w < 16; w++) begin
            fetch_word(make_addr(21'h2, 5'd8, 4'(w)) | 32'(w % 4));  // Odd byte offsets too
        end
        report_test("line hits");
        fetch_word(make_addr(21'h10, 5'd5, 4'd0));   // A fills
        fetch_word(make_addr(21'h20, 5'd5, 4'd1));   // B fills
        fetch_word(make_addr(21'h10, 5'd5, 4'd2));
        fetch_word(make_addr(21'h20, 5'd5, 4'd3));
        fetch_word(make_addr(21'h10, 5'd5, 4'd4));   // Touching A leaves B as LRU
        fetch_word(make_addr(21'h30, 5'd5, 4'd5));   // C evicts B
        fetch_word(make_addr(21'h10, 5'd5, 4'd6));   // A still hits
        fetch_word(make_addr(21'h20, 5'd5, 4'd7));   // B misses again
        report_test("lru eviction");
        for (int i = 0; i < 14; i++) begin
            set_sel  = 5'(16 + ($urandom % 4));
            tag_sel  = icache_pkg::tag_t'(32'h100 + ($urandom % 4));
            word_sel = 4'($urandom % 16);
            fetch_word(make_addr(tag_sel, set_sel, word_sel));
        end
        report_test("random fetches");
        repeat (4) @(posedge clk);
        $display("tests %0d, fetches %0d, misses %0d, failures %0d",
                 tests, fetches, misses, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(clk_period * (max_fetches * fetch_cycles + 200));
        $display("watchdog expired, the run took longer than %0d fetches allow", max_fetches);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog/icache_array_if.sv ====
`timescale 1ns/1ps

interface icache_array_if;

    logic [icache_pkg::idx_w-1:0] index;         // Set being read or refilled
    icache_pkg::tag_t             tag;           // Tag to compare or store
    logic [icache_pkg::sel_w-1:0] word_sel;      // Word within the line
    logic                         rd_en;         // Lookup strobe
    logic                         refill;        // Line write strobe
    logic [icache_pkg::way_w-1:0] refill_way;    // Way chosen for the refill
    icache_pkg::line_t            refill_line;   // Line from L2
    logic                         hit;           // Valid the cycle after rd_en
    logic [icache_pkg::way_w-1:0] hit_way;       // Way that matched
    logic [icache_pkg::way_w-1:0] victim_way;    // Way to replace on a miss
    logic [icache_pkg::word_w-1:0] word;         // Selected instruction word

    modport ctrl (
        output index, tag, word_sel, rd_en, refill, refill_way, refill_line,
        input  hit, hit_way, victim_way, word
    );

    modport tag_side (
        input  index, tag, rd_en, refill, refill_way,
        output hit, hit_way, victim_way
    );

    modport data_side (
        input  index, word_sel, rd_en, refill, refill_way, refill_line, hit_way,
        output word
    );

endinterface

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fetch,        // One cycle fetch strobe
    input  logic [icache_pkg::addr_w-1:0] fetch_addr,
    input  logic                          l2_valid,     // Line return strobe
    input  icache_pkg::line_t             l2_line,
    output logic                          busy,         // Core must hold off fetch
    output logic                          rsp_valid,
    output logic [icache_pkg::word_w-1:0] rsp_word,
    output logic                          l2_req,       // Line request strobe
    output logic [icache_pkg::addr_w-1:0] l2_addr,      // Line aligned
    icache_array_if.ctrl                  arr
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,                               // Array result visible
        st_miss_wait,                            // Waiting for L2
        st_refill,                               // Writing the line
        st_reread                                // Lookup again after refill
    } state_t;

    state_t                        state_q;
    logic [icache_pkg::addr_w-1:0] addr_q;       // Address of the fetch in flight
    logic [icache_pkg::addr_w-1:0] cur_addr;     // Address seen by the arrays
    icache_pkg::line_t             line_q;       // Line captured from L2
    logic [icache_pkg::way_w-1:0]  way_q;        // Victim fixed at miss time
    logic                          rsp_valid_q;
    logic [icache_pkg::word_w-1:0] rsp_word_q;
    logic                          l2_req_q;

    // In idle the lookup starts straight from the port
    assign cur_addr = (state_q == st_idle) ? fetch_addr : addr_q;

    assign arr.tag      = cur_addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign arr.index    = cur_addr[icache_pkg::off_w +: icache_pkg::idx_w];
    assign arr.word_sel = cur_addr[icache_pkg::off_w-1 -: icache_pkg::sel_w];  // Bits 5:2

    assign arr.rd_en       = ((state_q == st_idle) && fetch) || (state_q == st_reread);
    assign arr.refill      = (state_q == st_refill);
    assign arr.refill_way  = way_q;
    assign arr.refill_line = line_q;

    assign busy      = (state_q != st_idle) || rsp_valid_q;  // Covers the response cycle
    assign rsp_valid = rsp_valid_q;
    assign rsp_word  = rsp_word_q;
    assign l2_req    = l2_req_q;
    assign l2_addr   = {addr_q[icache_pkg::addr_w-1:icache_pkg::off_w], {icache_pkg::off_w{1'b0}}};

    // Control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= st_idle;
            rsp_valid_q <= 1'b0;
            l2_req_q    <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;                 // Strobes default low
            l2_req_q    <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (fetch) begin
                        state_q <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (arr.hit) begin
                        rsp_valid_q <= 1'b1;     // 2 cycles after rd_en
                        state_q     <= st_idle;
                    end else begin
                        l2_req_q <= 1'b1;        // 2 cycles after fetch
                        state_q  <= st_miss_wait;
                    end
                end
                st_miss_wait: begin
                    if (l2_valid) begin
                        state_q <= st_refill;
                    end
                end
                st_refill: state_q <= st_reread;
                st_reread: state_q <= st_lookup; // Refilled line now hits
                default:   state_q <= st_idle;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && fetch) begin
            addr_q <= fetch_addr;
        end
        if ((state_q == st_lookup) && !arr.hit) begin
            way_q <= arr.victim_way;             // Replacement choice at miss
        end
        if ((state_q == st_miss_wait) && l2_valid) begin
            line_q <= l2_line;
        end
        if ((state_q == st_lookup) && arr.hit) begin
            rsp_word_q <= arr.word;
        end
    end

    // No back-pressure, so a fetch while busy is lost
    a_no_fetch_busy : assert property (
        @(posedge clk) disable iff (!rst_n) fetch |-> !busy
    ) else $error("icache_ctrl: fetch while busy");

    // Only one miss outstanding
    a_l2_valid_expected : assert property (
        @(posedge clk) disable iff (!rst_n) l2_valid |-> (state_q == st_miss_wait)
    ) else $error("icache_ctrl: l2_valid without an outstanding request");

    // Every response closes a lookup started two cycles earlier
    a_rsp_after_lookup : assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> $past(arr.rd_en, 2)
    ) else $error("icache_ctrl: rsp_valid without a preceding lookup");

endmodule

// ==== verilog/icache_data_array.sv ====
`timescale 1ns/1ps

module icache_data_array (
    input logic               clk,
    input logic               rst_n,
    icache_array_if.data_side arr
);

    icache_pkg::line_t            rd_line [icache_pkg::ways];   // Both ways of the read set
    logic [icache_pkg::sel_w-1:0] sel_q;                        // Word select of that read

    // One line RAM per way, so both ways come out side by side
    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        icache_ram #(
            .depth     (icache_pkg::sets),
            .payload_t (icache_pkg::line_t)
        ) line_ram_i (
            .clk   (clk),
            .we    (arr.refill && (arr.refill_way == icache_pkg::way_w'(w))),  // Chosen way
            .waddr (arr.index),
            .wdata (arr.refill_line),
            .re    (arr.rd_en),
            .raddr (arr.index),
            .rdata (rd_line[w])
        );
    end

    // Word select travels with the RAM read register
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            sel_q <= arr.word_sel;
        end
    end

    // Way picked late, once the tag compare is known
    assign arr.word = rd_line[arr.hit_way][sel_q * icache_pkg::word_w +: icache_pkg::word_w];

    // An unknown way would write garbage into either half
    a_refill_way_known : assert property (
        @(posedge clk) disable iff (!rst_n) arr.refill |-> !$isunknown(arr.refill_way)
    ) else $error("icache_data_array: refill_way unknown during refill");

endmodule

// ==== verilog/icache_pkg.sv ====
package icache_pkg;

    // Fetch address layout: tag | index | offset
    localparam int addr_w = 32;                       // Core fetch address
    localparam int off_w  = 6;                        // Byte offset inside a 64 byte line
    localparam int idx_w  = 5;                        // Set index
    localparam int tag_w  = addr_w - idx_w - off_w;   // Remaining upper bits, 21

    // Cache geometry
    localparam int sets   = 1 << idx_w;               // 32 sets
    localparam int ways   = 2;                        // Two way set associative
    localparam int way_w  = 1;                        // Way number width

    // Line and word sizes
    localparam int line_w = 512;                      // Full line as returned by L2
    localparam int word_w = 32;                       // One instruction word
    localparam int sel_w  = 4;                        // Word select, offset bits 5:2

    // A whole cache line, word 0 in the low bits
    typedef logic [line_w-1:0] line_t;

    // Stored tag per way
    typedef logic [tag_w-1:0] tag_t;

endpackage

// ==== verilog/icache_ram.sv ====
`timescale 1ns/1ps

module icache_ram #(
    parameter int  depth     = 32,              // Number of entries
    parameter type payload_t = logic [31:0]     // Stored entry type
) (
    input  logic                     clk,
    input  logic                     we,        // Write strobe
    input  logic [$clog2(depth)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic                     re,        // Read strobe
    input  logic [$clog2(depth)-1:0] raddr,
    output payload_t                 rdata      // Registered, one cycle after re
);

    payload_t mem [depth];                      // Storage, no reset on contents

    // One write port, one read port, same clock
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                // Full entry write
        end
    end

    // Output register holds its value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];                // Old data on a same-address write
        end
    end

    // The read would return the stale entry, so the cache never does this
    a_no_rw_collision : assert property (
        @(posedge clk) !(we && re && (waddr == raddr))
    ) else $error("icache_ram: read and write to address %0d in one cycle", raddr);

endmodule

// ==== verilog/icache_tag_array.sv ====
`timescale 1ns/1ps

module icache_tag_array (
    input logic              clk,
    input logic              rst_n,
    icache_array_if.tag_side arr
);

    icache_pkg::tag_t             rd_tag [icache_pkg::ways];    // Per way RAM output
    icache_pkg::tag_t             tag_q;                        // Tag of the pending lookup
    logic [icache_pkg::idx_w-1:0] idx_q;                        // Index of the pending lookup
    logic                         rd_q;                         // Lookup result is due
    logic [icache_pkg::ways-1:0]  valid_q [icache_pkg::sets];   // Valid bit per way and set
    logic [icache_pkg::way_w-1:0] lru_q [icache_pkg::sets];     // Names the next victim
    logic [icache_pkg::ways-1:0]  match;                        // Per way tag match

    // One tag RAM per way, written only for the refilled way
    for (genvar w = 0; w < icache_pkg::ways; w++) begin : g_way
        icache_ram #(
            .depth     (icache_pkg::sets),
            .payload_t (icache_pkg::tag_t)
        ) tag_ram_i (
            .clk   (clk),
            .we    (arr.refill && (arr.refill_way == icache_pkg::way_w'(w))),
            .waddr (arr.index),
            .wdata (arr.tag),
            .re    (arr.rd_en),
            .raddr (arr.index),
            .rdata (rd_tag[w])
        );
    end

    // Lookup key follows the RAM read by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
        end else begin
            rd_q <= arr.rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            tag_q <= arr.tag;                   // Payload only, no reset
            idx_q <= arr.index;
        end
    end

    // Compare registered tag against both RAM outputs
    always_comb begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            match[w] = valid_q[idx_q][w] && (rd_tag[w] == tag_q);
        end
    end

    assign arr.hit = rd_q && (|match);          // Only meaningful after rd_en

    always_comb begin
        arr.hit_way = '0;
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (match[w]) begin
                arr.hit_way = icache_pkg::way_w'(w);
            end
        end
    end

    // First invalid way wins, else follow the replacement bit
    always_comb begin
        arr.victim_way = lru_q[idx_q];
        for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
            if (!valid_q[idx_q][w]) begin
                arr.victim_way = icache_pkg::way_w'(w);
            end
        end
    end

    // Valid and replacement state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '{default: '0};
            lru_q   <= '{default: '0};
        end else if (arr.refill) begin
            valid_q[arr.index][arr.refill_way] <= 1'b1;
            lru_q[arr.index] <= ~arr.refill_way;    // Point away from the new line
        end else if (arr.hit) begin
            lru_q[idx_q] <= ~arr.hit_way;           // Point away from the used way
        end
    end

    // A line is never in two ways of one set
    a_single_hit : assert property (
        @(posedge clk) disable iff (!rst_n) rd_q |-> $onehot0(match)
    ) else $error("icache_tag_array: set %0d hits in more than one way", idx_q);

endmodule

// ==== verilog/l1_icache.sv ====
`timescale 1ns/1ps

module l1_icache (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fetch,        // Core fetch strobe
    input  logic [icache_pkg::addr_w-1:0] fetch_addr,
    input  logic                          l2_valid,     // L2 line strobe
    input  icache_pkg::line_t             l2_line,
    output logic                          busy,
    output logic                          rsp_valid,
    output logic [icache_pkg::word_w-1:0] rsp_word,
    output logic                          l2_req,
    output logic [icache_pkg::addr_w-1:0] l2_addr
);

    icache_array_if arr_if ();                  // Controller to array signals

    // FSM, address split and L2 side
    icache_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .l2_valid   (l2_valid),
        .l2_line    (l2_line),
        .busy       (busy),
        .rsp_valid  (rsp_valid),
        .rsp_word   (rsp_word),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .arr        (arr_if.ctrl)
    );

    // Tags, valid bits, replacement
    icache_tag_array tag_i (
        .clk   (clk),
        .rst_n (rst_n),
        .arr   (arr_if.tag_side)
    );

    // Line storage, word select
    icache_data_array data_i (
        .clk   (clk),
        .rst_n (rst_n),
        .arr   (arr_if.data_side)
    );

endmodule
